/* bench/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core_tb;
    localparam int CLK_PERIOD = 8;
    localparam int N_TESTS    = 6;
    localparam int RUN_LIMIT  = 300;    // cycles per program after reset

    logic        clk;
    logic        reset;
    logic        i_imem_we;
    logic [7:0]  i_imem_addr;
    logic [31:0] i_imem_data;
    logic        o_uart_en;
    logic [7:0]  o_uart_data;

    logic [31:0] prog [$];
    logic [7:0]  exp_q [$];
    logic [7:0]  uart_q [$];
    logic [31:0] regs [32];             // architectural register model
    logic [31:0] lfsr;
    int          errors;
    int          reset_strobes;

    rv_core i_dut (
        .clk         (clk),
        .reset       (reset),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .o_uart_en   (o_uart_en),
        .o_uart_data (o_uart_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // sampled mid-cycle, outputs settled
    always @(negedge clk) begin
        if (o_uart_en) begin
            if (reset) begin
                $display("uart strobe seen while reset is held");
                reset_strobes++;
            end else begin
                uart_q.push_back(o_uart_data);
            end
        end
    end

    function automatic logic lfsr_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    // k: add sub sll slt sltu xor srl sra or and
    function automatic logic [2:0] alu_f3(int k);
        case (k)
            0, 1:    return 3'b000;
            2:       return 3'b001;
            3:       return 3'b010;
            4:       return 3'b011;
            5:       return 3'b100;
            6, 7:    return 3'b101;
            8:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic logic [6:0] alu_f7(int k);
        return (k == 1 || k == 7) ? 7'h20 : 7'h00;
    endfunction

    function automatic logic [31:0] alu_ref(int k, logic [31:0] a, logic [31:0] b);
        case (k)
            0:       return a + b;
            1:       return a - b;
            2:       return a << b[4:0];    // shift amount is five bits
            3:       return {31'd0, $signed(a) < $signed(b)};
            4:       return {31'd0, a < b};
            5:       return a ^ b;
            6:       return a >> b[4:0];
            7:       return $signed(a) >>> b[4:0];
            8:       return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] cur_pc();
        return 32'(prog.size() * 4);
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_const(int rd, logic [31:0] v);
        logic [31:0] upper;
        upper = (v + 32'h800) >> 12;        // addi sign-extends the low part
        prog.push_back(enc_u(upper[19:0], 5'(rd), `RV_OP_LUI));
        prog.push_back(enc_i(v[11:0], 5'(rd), 3'b000, 5'(rd), `RV_OP_IMM));
        regs[rd] = v;
    endtask

    task automatic op_rr(int k, int rd, int rs1, int rs2);
        prog.push_back(enc_r(alu_f7(k), 5'(rs2), 5'(rs1), alu_f3(k), 5'(rd)));
        regs[rd] = alu_ref(k, regs[rs1], regs[rs2]);
    endtask

    task automatic op_ri(int k, int rd, int rs1, logic [11:0] imm);
        logic [11:0] imm12;
        imm12 = (k == 2 || k == 6 || k == 7) ? {alu_f7(k), imm[4:0]} : imm;
        prog.push_back(enc_i(imm12, 5'(rs1), alu_f3(k), 5'(rd), `RV_OP_IMM));
        regs[rd] = alu_ref(k, regs[rs1], {{20{imm12[11]}}, imm12});
    endtask

    // sb to the uart address, x31 holds its base
    task automatic send(int rs, logic expect_it);
        prog.push_back(enc_s(12'h020, 5'(rs), 5'd31, 3'b000));
        if (expect_it) begin
            exp_q.push_back(regs[rs][7:0]);
        end
    endtask

    task automatic start_program();
        prog.delete();
        exp_q.delete();
        regs[0] = '0;
        load_const(31, `RV_UART_TX_ADDR - 32'h20);
    endtask

    task automatic run_program(string name, int min_cycles);
        int cycles;
        int base;
        int got;
        prog.push_back(enc_j(21'd0, 5'd0));    // park on jal to self
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            i_imem_we   <= 1'b1;
            i_imem_addr <= 8'(i);
            i_imem_data <= prog[i];
        end
        @(posedge clk);
        i_imem_we <= 1'b0;
        repeat (10) @(posedge clk);
        base = uart_q.size();
        reset <= 1'b0;
        cycles = 0;
        while ((uart_q.size() - base < exp_q.size() || cycles < min_cycles)
               && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        got = uart_q.size() - base;
        for (int i = 0; i < exp_q.size(); i++) begin
            if (i < got) begin
                check_value(name, {24'h0, exp_q[i]}, {24'h0, uart_q[base + i]});
            end else begin
                $display("%s: uart byte %0d never arrived", name, i);
                errors++;
            end
        end
        if (got > exp_q.size()) begin
            $display("%s: %0d uart bytes more than expected", name, got - exp_q.size());
            errors++;
        end
    endtask

    task automatic branch_case(logic [2:0] f3, int rs1, int rs2);
        logic taken;
        taken = branch_ref(f3, regs[rs1], regs[rs2]);
        op_ri(0, 7, 7, 12'd1);              // case counter
        prog.push_back(enc_b(13'd12, 5'(rs2), 5'(rs1), f3));
        send(5, !taken);
        send(6, !taken);
        send(7, 1'b1);
    endtask

    task automatic test_reset_quiet();
        start_program();
        load_const(1, 32'h0000_1234);
        load_const(2, 32'h0000_00ff);
        op_rr(0, 3, 1, 2);
        op_ri(5, 4, 3, 12'h0f0);
        run_program("reset_quiet", 40);
    endtask

    task automatic test_alu_ops();
        start_program();
        load_const(1, 32'hf0f0_1234);
        load_const(2, 32'h8000_0013);
        for (int k = 0; k < 10; k++) begin
            op_rr(k, 3, 1, 2);
            send(3, 1'b1);
        end
        for (int k = 0; k < 10; k++) begin
            if (k != 1) begin
                op_ri(k, 3, 1, 12'h92d);
                send(3, 1'b1);
            end
        end
        prog.push_back(enc_u(20'habcde, 5'd4, `RV_OP_LUI));
        regs[4] = {20'habcde, 12'h000};
        op_ri(6, 5, 4, 12'd12);
        send(5, 1'b1);
        regs[6] = cur_pc() + {20'h00001, 12'h000};
        prog.push_back(enc_u(20'h00001, 5'd6, `RV_OP_AUIPC));
        send(6, 1'b1);
        op_ri(6, 7, 6, 12'd8);
        send(7, 1'b1);
        run_program("alu_ops", 0);
    endtask

    task automatic test_forwarding();
        start_program();
        load_const(1, 32'h1357_9bdf);
        load_const(2, 32'h2468_ace0);
        op_rr(0, 3, 1, 2);
        send(3, 1'b1);
        op_rr(5, 3, 3, 1);
        op_rr(0, 4, 3, 3);
        send(4, 1'b1);
        op_rr(5, 1, 4, 2);
        op_rr(0, 1, 1, 1);
        send(1, 1'b1);
        op_ri(0, 2, 1, 12'h7ff);
        op_rr(5, 2, 2, 1);
        send(2, 1'b1);
        send(3, 1'b1);
        run_program("forwarding", 0);
    endtask

    task automatic test_control_flow();
        logic [31:0] p0;
        start_program();
        load_const(1, 32'd5);
        load_const(2, 32'hffff_fffd);
        load_const(3, 32'd5);
        load_const(5, 32'h11);
        load_const(6, 32'h22);
        load_const(7, 32'h0);
        branch_case(3'b000, 1, 3);
        branch_case(3'b000, 1, 2);
        branch_case(3'b001, 1, 2);
        branch_case(3'b001, 1, 3);
        branch_case(3'b100, 2, 1);
        branch_case(3'b100, 1, 2);
        branch_case(3'b101, 1, 2);
        branch_case(3'b101, 2, 1);
        branch_case(3'b110, 1, 2);
        branch_case(3'b110, 2, 1);
        branch_case(3'b111, 2, 1);
        branch_case(3'b111, 1, 2);
        regs[8] = cur_pc() + 32'd4;
        prog.push_back(enc_j(21'd12, 5'd8));
        send(5, 1'b0);
        send(6, 1'b0);
        send(8, 1'b1);
        p0 = cur_pc();
        load_const(10, p0 + 32'd21);        // jalr target with bit 0 set
        regs[9] = cur_pc() + 32'd4;
        prog.push_back(enc_i(12'h000, 5'd10, 3'b000, 5'd9, `RV_OP_JALR));
        send(5, 1'b0);
        send(6, 1'b0);
        send(9, 1'b1);
        run_program("control_flow", 0);
    endtask

    task automatic test_data_memory();
        start_program();
        load_const(11, 32'h0000_0040);
        load_const(12, 32'ha1b2_c3d4);
        load_const(13, 32'h0000_005e);
        prog.push_back(enc_s(12'd0, 5'd12, 5'd11, 3'b010));
        prog.push_back(enc_s(12'd2, 5'd13, 5'd11, 3'b000));
        prog.push_back(enc_i(12'd0, 5'd11, 3'b010, 5'd14, `RV_OP_LOAD));
        regs[14] = {regs[12][31:24], regs[13][7:0], regs[12][15:0]};
        send(14, 1'b1);
        for (int s = 1; s < 4; s++) begin
            op_ri(6, 15, 14, 12'(8 * s));
            send(15, 1'b1);
        end
        run_program("data_memory", 0);
    endtask

    task automatic test_random_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic        use_imm;
        int          k;
        start_program();
        for (int n = 0; n < 20; n++) begin
            a       = rand_bits(32);
            b       = rand_bits(32);
            k       = int'(rand_bits(4) % 32'd10);
            use_imm = lfsr_bit();
            load_const(1, a);
            load_const(2, b);
            if (use_imm && k != 1) begin
                imm = 12'(rand_bits(12));
                op_ri(k, 3, 1, imm);
            end else begin
                op_rr(k, 3, 1, 2);
            end
            send(3, 1'b1);
        end
        run_program("random_ops", 0);
    endtask

    initial begin
        reset         = 1'b1;
        i_imem_we     = 1'b0;
        i_imem_addr   = '0;
        i_imem_data   = '0;
        lfsr          = 32'h734b;
        errors        = 0;
        reset_strobes = 0;
        test_reset_quiet();
        test_alu_ops();
        test_forwarding();
        test_control_flow();
        test_data_memory();
        test_random_ops();
        $display("errors: %0d check, %0d strobe in reset", errors, reset_strobes);
        if (errors == 0 && reset_strobes == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(N_TESTS * 400 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, tests did not finish", N_TESTS * 400);
        $display("errors: %0d check, %0d strobe in reset", errors, reset_strobes);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* design/rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core import rv_core_pkg::*; (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              i_imem_we,
    input  logic [$clog2(`RV_IMEM_WORDS)-1:0] i_imem_addr,
    input  rv_word_t                          i_imem_data,
    output logic                              o_uart_en,
    output logic [7:0]                        o_uart_data
);
    rv_word_t            inst;
    rv_word_t            pc_d;
    rv_word_t            pc_plus_d;
    rv_de_ex_t           de_ex;
    logic [`RV_XLEN-3:0] dmem_addr;
    logic [3:0]          dmem_be;
    rv_word_t            dmem_wdata;
    rv_word_t            dmem_rdata;

    rv_exec_result_if ex_if (.clk(clk));

    rv_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .ex          (ex_if.fetch_sink),
        .o_inst      (inst),
        .o_pc        (pc_d),
        .o_pc_plus   (pc_plus_d)
    );

    rv_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .i_inst    (inst),
        .i_pc      (pc_d),
        .i_pc_plus (pc_plus_d),
        .ex        (ex_if.decode_sink),
        .o_de_ex   (de_ex)
    );

    rv_execute u_execute (
        .i_de_ex      (de_ex),
        .ex           (ex_if.src),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_be    (dmem_be),
        .o_dmem_wdata (dmem_wdata),
        .i_dmem_rdata (dmem_rdata),
        .o_uart_en    (o_uart_en),
        .o_uart_data  (o_uart_data)
    );

    rv_dmem u_dmem (
        .clk     (clk),
        .i_addr  (dmem_addr),
        .i_be    (dmem_be),
        .i_wdata (dmem_wdata),
        .o_rdata (dmem_rdata)
    );

endmodule

/* design/rv_core_defines.svh */
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

`define RV_XLEN         32
`define RV_IMEM_WORDS   256
`define RV_DMEM_WORDS   256

// sb here drives the uart strobe
`define RV_UART_TX_ADDR 32'h20020

`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_IMM       7'b0010011
`define RV_OP_REG       7'b0110011

`endif

/* design/rv_core_pkg.sv */
package rv_core_pkg;

`include "rv_core_defines.svh"

    typedef logic [`RV_XLEN-1:0] rv_word_t;
    typedef logic [4:0]          rv_reg_t;

    // zero value is the bubble
    typedef enum logic [5:0] {
        OP_NONE = 6'd0,
        OP_LUI, OP_AUIPC,
        OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LW, OP_SB, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND
    } rv_op_e;

    typedef struct packed {
        rv_op_e   op;
        rv_word_t pc;
        rv_word_t pc_plus;
        rv_reg_t  rd;
        rv_word_t a;        // rs1, forwarded
        rv_word_t b;        // rs2, forwarded
        rv_word_t imm;      // already picked by format
    } rv_de_ex_t;

endpackage

/* design/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_decode import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_word_t              i_inst,
    input  rv_word_t              i_pc,
    input  rv_word_t              i_pc_plus,
    rv_exec_result_if.decode_sink ex,
    output rv_de_ex_t             o_de_ex
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rv_reg_t    rd;
    rv_reg_t    rs1;
    rv_reg_t    rs2;
    rv_op_e     op;
    rv_word_t   imm;
    rv_word_t   a;
    rv_word_t   b;
    rv_word_t   rf [1:31];     // x0 is not stored
    logic       rf_we;
    rv_de_ex_t  de;

    assign opcode = i_inst[6:0];
    assign rd     = i_inst[11:7];
    assign funct3 = i_inst[14:12];
    assign rs1    = i_inst[19:15];
    assign rs2    = i_inst[24:20];
    assign funct7 = i_inst[31:25];

    always_comb begin
        op = OP_NONE;           // dropped encodings stay here
        case (opcode)
            `RV_OP_LUI:    op = OP_LUI;
            `RV_OP_AUIPC:  op = OP_AUIPC;
            `RV_OP_JAL:    op = OP_JAL;
            `RV_OP_JALR:   op = (funct3 == 3'b000) ? OP_JALR : OP_NONE;
            `RV_OP_LOAD:   op = (funct3 == 3'b010) ? OP_LW : OP_NONE;
            `RV_OP_BRANCH: begin
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: op = OP_NONE;
                endcase
            end
            `RV_OP_STORE: begin
                case (funct3)
                    3'b000:  op = OP_SB;
                    3'b010:  op = OP_SW;
                    default: op = OP_NONE;
                endcase
            end
            `RV_OP_IMM: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b001}: op = OP_SLLI;
                    {7'b0000000, 3'b101}: op = OP_SRLI;
                    {7'b0100000, 3'b101}: op = OP_SRAI;
                    default: begin
                        case (funct3)
                            3'b000:  op = OP_ADDI;
                            3'b010:  op = OP_SLTI;
                            3'b011:  op = OP_SLTIU;
                            3'b100:  op = OP_XORI;
                            3'b110:  op = OP_ORI;
                            3'b111:  op = OP_ANDI;
                            default: op = OP_NONE;  // bad shift funct7
                        endcase
                    end
                endcase
            end
            `RV_OP_REG: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: op = OP_ADD;
                    {7'b0100000, 3'b000}: op = OP_SUB;
                    {7'b0000000, 3'b001}: op = OP_SLL;
                    {7'b0000000, 3'b010}: op = OP_SLT;
                    {7'b0000000, 3'b011}: op = OP_SLTU;
                    {7'b0000000, 3'b100}: op = OP_XOR;
                    {7'b0000000, 3'b101}: op = OP_SRL;
                    {7'b0100000, 3'b101}: op = OP_SRA;
                    {7'b0000000, 3'b110}: op = OP_OR;
                    {7'b0000000, 3'b111}: op = OP_AND;
                    default:              op = OP_NONE;   // mul/div land here
                endcase
            end
            default: op = OP_NONE;
        endcase
    end

    always_comb begin
        case (opcode)
            `RV_OP_STORE:  imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            `RV_OP_BRANCH: imm = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25],
                                  i_inst[11:8], 1'b0};
            `RV_OP_JAL:    imm = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20],
                                  i_inst[30:21], 1'b0};
            `RV_OP_LUI,
            `RV_OP_AUIPC:  imm = {i_inst[31:12], 12'h000};
            default:       imm = {{20{i_inst[31]}}, i_inst[31:20]};   // i-type and shamt
        endcase
    end

    // the instruction in execute writes at this cycle's end, so bypass it
    assign a = (rs1 == '0) ? '0 :
               (ex.wb_en && ex.wb_rd == rs1) ? ex.wb_data : rf[rs1];
    assign b = (rs2 == '0) ? '0 :
               (ex.wb_en && ex.wb_rd == rs2) ? ex.wb_data : rf[rs2];

    assign de = '{op: op, pc: i_pc, pc_plus: i_pc_plus, rd: rd,
                  a: a, b: b, imm: imm};

    assign rf_we = ex.wb_en && (ex.wb_rd != '0);   // x0 writes dropped here

    always_ff @(posedge clk) begin
        if (rf_we) begin
            rf[ex.wb_rd] <= ex.wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || ex.redirect) begin
            o_de_ex <= '0;
        end else begin
            o_de_ex <= de;
        end
    end

endmodule

/* design/rv_dmem.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_dmem #(
    parameter int DEPTH_WORDS = `RV_DMEM_WORDS
) (
    input  logic                clk,
    input  logic [`RV_XLEN-3:0] i_addr,     // word address
    input  logic [3:0]          i_be,
    input  logic [`RV_XLEN-1:0] i_wdata,
    output logic [`RV_XLEN-1:0] o_rdata
);
    localparam int AW = $clog2(DEPTH_WORDS);

    logic [`RV_XLEN-1:0] mem [DEPTH_WORDS];
    logic [AW-1:0]       idx;

    assign idx = AW'(i_addr % DEPTH_WORDS);   // wraps on depth

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (i_be[i]) begin
                mem[idx][8*i +: 8] <= i_wdata[8*i +: 8];
            end
        end
    end

    assign o_rdata = mem[idx];

endmodule

/* design/rv_exec_result_if.sv */
`timescale 1ns/1ps

interface rv_exec_result_if import rv_core_pkg::*; (
    input logic clk
);
    logic     wb_en;        // register write this cycle
    rv_reg_t  wb_rd;
    rv_word_t wb_data;      // alu result or load data
    logic     redirect;     // taken branch or jump
    rv_word_t target;

    modport src (input clk, output wb_en, wb_rd, wb_data, redirect, target);
    modport fetch_sink (input redirect, target);
    modport decode_sink (input wb_en, wb_rd, wb_data, redirect, target);

endinterface

/* design/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_execute import rv_core_pkg::*; (
    input  rv_de_ex_t           i_de_ex,
    rv_exec_result_if.src       ex,
    output logic [`RV_XLEN-3:0] o_dmem_addr,
    output logic [3:0]          o_dmem_be,
    output rv_word_t            o_dmem_wdata,
    input  rv_word_t            i_dmem_rdata,
    output logic                o_uart_en,
    output logic [7:0]          o_uart_data
);
    rv_op_e   op;
    rv_word_t a;
    rv_word_t b;
    rv_word_t imm;
    rv_word_t rhs;
    rv_word_t sum_ai;
    rv_word_t alu_out;
    logic     use_imm;
    logic     eq;
    logic     lt;
    logic     ltu;
    logic     take;
    logic     write_back;
    logic     is_load;

    assign op  = i_de_ex.op;
    assign a   = i_de_ex.a;
    assign b   = i_de_ex.b;
    assign imm = i_de_ex.imm;

    assign use_imm = op inside {OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
                                OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI};
    assign rhs    = use_imm ? imm : b;
    assign sum_ai = a + imm;    // lw/sb/sw address and jalr target

    assign eq  = (a == rhs);
    assign lt  = ($signed(a) < $signed(rhs));
    assign ltu = (a < rhs);

    always_comb begin
        case (op)
            OP_ADD, OP_ADDI:   alu_out = a + rhs;
            OP_SUB:            alu_out = a - rhs;
            OP_AND, OP_ANDI:   alu_out = a & rhs;
            OP_OR, OP_ORI:     alu_out = a | rhs;
            OP_XOR, OP_XORI:   alu_out = a ^ rhs;
            OP_SLL, OP_SLLI:   alu_out = a << rhs[4:0];
            OP_SRL, OP_SRLI:   alu_out = a >> rhs[4:0];
            OP_SRA, OP_SRAI:   alu_out = $signed(a) >>> rhs[4:0];
            OP_SLT, OP_SLTI:   alu_out = {{(`RV_XLEN-1){1'b0}}, lt};
            OP_SLTU, OP_SLTIU: alu_out = {{(`RV_XLEN-1){1'b0}}, ltu};
            OP_LUI:            alu_out = imm;
            OP_AUIPC:          alu_out = i_de_ex.pc + imm;
            OP_JAL, OP_JALR:   alu_out = i_de_ex.pc_plus;   // link
            default:           alu_out = '0;
        endcase
    end

    always_comb begin
        case (op)
            OP_BEQ:          take = eq;
            OP_BNE:          take = !eq;
            OP_BLT:          take = lt;
            OP_BGE:          take = !lt;
            OP_BLTU:         take = ltu;
            OP_BGEU:         take = !ltu;
            OP_JAL, OP_JALR: take = 1'b1;
            default:         take = 1'b0;
        endcase
    end

    assign is_load    = (op == OP_LW);
    assign write_back = !(op inside {OP_NONE, OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
                                     OP_BLTU, OP_BGEU, OP_SB, OP_SW});

    assign ex.wb_en    = write_back;
    assign ex.wb_rd    = i_de_ex.rd;
    assign ex.wb_data  = is_load ? i_dmem_rdata : alu_out;
    assign ex.redirect = take;
    assign ex.target   = (op == OP_JALR) ? {sum_ai[`RV_XLEN-1:1], 1'b0}
                                         : i_de_ex.pc + imm;

    assign o_dmem_addr = sum_ai[`RV_XLEN-1:2];

    always_comb begin
        case (op)
            OP_SW:   o_dmem_be = 4'b1111;
            OP_SB:   o_dmem_be = 4'b0001 << sum_ai[1:0];
            default: o_dmem_be = 4'b0000;
        endcase
    end

    // byte copied to every lane, be picks the one
    assign o_dmem_wdata = (op == OP_SB) ? {4{b[7:0]}} : b;

    assign o_uart_en   = (op == OP_SB) && (sum_ai == `RV_UART_TX_ADDR);
    assign o_uart_data = o_uart_en ? b[7:0] : 8'h00;

    a_no_store_on_redirect : assert property (@(posedge ex.clk)
        ex.redirect |-> (o_dmem_be == 4'b0000))
        else $error("store issued together with a redirect");

endmodule

/* design/rv_fetch.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_fetch import rv_core_pkg::*; (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              i_imem_we,
    input  logic [$clog2(`RV_IMEM_WORDS)-1:0] i_imem_addr,
    input  rv_word_t                          i_imem_data,
    rv_exec_result_if.fetch_sink              ex,
    output rv_word_t                          o_inst,
    output rv_word_t                          o_pc,
    output rv_word_t                          o_pc_plus
);
    localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);

    rv_word_t imem [`RV_IMEM_WORDS];
    rv_word_t pc;
    rv_word_t pc_plus;

    assign pc_plus = pc + 'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (ex.redirect) begin
            pc <= ex.target;
        end else begin
            pc <= pc_plus;
        end
    end

    // program load port
    always_ff @(posedge clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    // fetch/decode register, the memory read is folded into it
    always_ff @(posedge clk) begin
        if (reset || ex.redirect) begin
            o_inst    <= '0;    // all-zero word decodes as a bubble
            o_pc      <= '0;
            o_pc_plus <= '0;
        end else begin
            o_inst    <= imem[pc[IMEM_AW+1:2]];
            o_pc      <= pc;
            o_pc_plus <= pc_plus;
        end
    end

    // the program is only placed while the core is held
    a_imem_load_in_reset : assert property (@(posedge clk) i_imem_we |-> reset)
        else $error("instruction memory written outside reset");

endmodule

/* run.sh */
#!/bin/sh
# build and run the rv_core testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0

/* rv_core.f */
+incdir+design
design/rv_core_pkg.sv
design/rv_exec_result_if.sv
design/rv_dmem.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_core.sv
bench/rv_core_tb.sv
